// ==== soc_domain.f ====
logic/soc_pkg.sv
logic/obi_bus_if.sv
logic/obi_addr_demux.sv
logic/sram_bank.sv
logic/soc_ctrl_regs.sv
logic/gpio_ctrl.sv
logic/timer_unit.sv
logic/soc_domain.sv
tests/soc_domain_chk.sv
tests/soc_domain_tb.sv

// ==== Makefile ====
# Verilator build and run for the SoC peripheral domain

VERILATOR ?= verilator
TOP       ?= soc_domain_tb
FILELIST  ?= soc_domain.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/soc_domain_tb.sv ====
/*
 * Testbench for the SoC peripheral domain
 * Table-driven bus accesses to SRAM, error window and SoC control,
 * followed by GPIO, back-to-back and timer sequences
 */
`timescale 1ns/1ns
`default_nettype none

module soc_domain_tb
  import soc_pkg::*;
();

  localparam int unsigned GpioCount      = 8;
  localparam int unsigned SramNumWords   = 256;
  localparam int unsigned NumRows        = 31;
  localparam int unsigned WatchdogCycles = NumRows * 4 + 200;
  localparam int unsigned TimerCmp       = 5;

  localparam logic [GpioCount-1:0] DirVal = 8'hA5;
  localparam logic [GpioCount-1:0] OutVal = 8'h3C;
  localparam logic [GpioCount-1:0] InVal  = 8'h5A;

  typedef enum logic {OP_READ, OP_WRITE} op_e;

  typedef struct packed {
    op_e   op;
    addr_t addr;
    be_t   be;
    data_t wdata;
    data_t exp_rdata;
    logic  exp_err;
  } row_t;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 bus_req_i;
  logic                 bus_we_i;
  addr_t                bus_addr_i;
  be_t                  bus_be_i;
  data_t                bus_wdata_i;
  logic                 bus_gnt_o;
  logic                 bus_rvalid_o;
  data_t                bus_rdata_o;
  logic                 bus_err_o;
  logic [GpioCount-1:0] gpio_i;
  logic [GpioCount-1:0] gpio_o;
  logic [GpioCount-1:0] gpio_out_en_o;
  irq_vec_t             irq_o;
  logic                 fetch_en_i;
  addr_t                boot_addr_o;
  logic                 fetch_en_o;

  row_t        rows [NumRows];
  int          row_cnt;
  int          seg_end [4];
  data_t       sram_model [8];

  soc_domain #(
    .GpioCount    ( GpioCount    ),
    .SramNumWords ( SramNumWords )
  ) u_soc_domain (
    .clk_i,
    .rst_n_i,
    .bus_req_i,
    .bus_we_i,
    .bus_addr_i,
    .bus_be_i,
    .bus_wdata_i,
    .bus_gnt_o,
    .bus_rvalid_o,
    .bus_rdata_o,
    .bus_err_o,
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .irq_o,
    .fetch_en_i,
    .boot_addr_o,
    .fetch_en_o
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d clock periods", WatchdogCycles);
    abort_run();
  end

  // --------------------------------------------------------------------
  // Reporting and compare tasks
  // --------------------------------------------------------------------
  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_data(input data_t act, input data_t exp, input string what);
    if (act !== exp) begin
      $display("ERR @%0t: %s is %h, expected %h", $time, what, act, exp);
      abort_run();
    end
  endtask

  task automatic check_err(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      $display("ERR @%0t: %s err is %b, expected %b", $time, what, act, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      $display("ERR @%0t: %s is %b, expected %b", $time, what, act, exp);
      abort_run();
    end
  endtask

  task automatic check_irq(input irq_vec_t act, input irq_vec_t exp, input string what);
    if (act !== exp) begin
      $display("ERR @%0t: %s irq_o is %b, expected %b", $time, what, act, exp);
      abort_run();
    end
  endtask

  task automatic check_gpio(input logic [GpioCount-1:0] act, input logic [GpioCount-1:0] exp,
                            input string what);
    if (act !== exp) begin
      $display("ERR @%0t: %s is %h, expected %h", $time, what, act, exp);
      abort_run();
    end
  endtask

  // Reference byte merge under enables
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, be_t be);
    data_t res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = be[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
    end
    return res;
  endfunction

  function automatic addr_t sram_addr(int unsigned idx);
    return SramBase + addr_t'(idx * 4);
  endfunction

  function automatic row_t make_row(op_e op, addr_t addr, be_t be, data_t wdata,
                                    data_t exp_rdata, logic exp_err);
    row_t r;
    r.op        = op;
    r.addr      = addr;
    r.be        = be;
    r.wdata     = wdata;
    r.exp_rdata = exp_rdata;
    r.exp_err   = exp_err;
    return r;
  endfunction

  task automatic add_row(input op_e op, input addr_t addr, input be_t be, input data_t wdata,
                         input data_t exp_rdata, input logic exp_err);
    rows[row_cnt] = make_row(op, addr, be, wdata, exp_rdata, exp_err);
    row_cnt++;
  endtask

  // --------------------------------------------------------------------
  // Bus driver called on a falling edge
  // --------------------------------------------------------------------
  task automatic idle_bus();
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    bus_addr_i  = '0;
    bus_be_i    = '0;
    bus_wdata_i = '0;
  endtask

  task automatic await_grant();
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (bus_gnt_o !== 1'b1) begin
      waited++;
      if (waited > 8) begin
        $display("Timeout: request to %h was never granted", bus_addr_i);
        abort_run();
      end
      @(posedge clk_i);
    end
  endtask

  // Response is checked on the falling edge after acceptance
  task automatic access(input row_t r);
    bus_req_i   = 1'b1;
    bus_we_i    = (r.op == OP_WRITE);
    bus_addr_i  = r.addr;
    bus_be_i    = r.be;
    bus_wdata_i = r.wdata;
    await_grant();
    @(negedge clk_i);
    check_bit(bus_rvalid_o, 1'b1, $sformatf("rvalid for %h", r.addr));
    check_data(bus_rdata_o, r.exp_rdata, $sformatf("rdata for %h", r.addr));
    check_err(bus_err_o, r.exp_err, $sformatf("access to %h", r.addr));
  endtask

  // Rows of one segment go out on consecutive cycles
  task automatic run_rows(input int first, input int last);
    for (int i = first; i < last; i++) begin
      access(rows[i]);
    end
    idle_bus();
    @(negedge clk_i);
    check_bit(bus_rvalid_o, 1'b0, "rvalid with no request");
  endtask

  task automatic write_reg(input addr_t addr, input data_t wdata);
    access(make_row(OP_WRITE, addr, 4'hF, wdata, '0, 1'b0));
    idle_bus();
  endtask

  task automatic read_reg(input addr_t addr, input data_t exp_rdata);
    access(make_row(OP_READ, addr, 4'hF, '0, exp_rdata, 1'b0));
    idle_bus();
  endtask

  task automatic wait_irq(input int idx, input int limit);
    int waited;
    waited = 0;
    while (irq_o[idx] !== 1'b1) begin
      @(negedge clk_i);
      waited++;
      if (waited > limit) begin
        $display("Timeout: irq_o[%0d] did not rise within %0d cycles", idx, limit);
        abort_run();
      end
    end
  endtask

  task automatic build_table();
    data_t rnd;
    row_cnt = 0;
    // SRAM full writes and two partial writes then read back
    for (int i = 0; i < 8; i++) begin
      rnd           = $urandom;
      sram_model[i] = rnd;
      add_row(OP_WRITE, sram_addr(i), 4'hF, rnd, '0, 1'b0);
    end
    rnd           = $urandom;
    sram_model[2] = merge_bytes(sram_model[2], rnd, 4'b0101);
    add_row(OP_WRITE, sram_addr(2), 4'b0101, rnd, '0, 1'b0);
    rnd           = $urandom;
    sram_model[5] = merge_bytes(sram_model[5], rnd, 4'b1000);
    add_row(OP_WRITE, sram_addr(5), 4'b1000, rnd, '0, 1'b0);
    for (int i = 0; i < 8; i++) begin
      add_row(OP_READ, sram_addr(i), 4'hF, '0, sram_model[i], 1'b0);
    end
    seg_end[0] = row_cnt;
    // Unmapped accesses then SRAM word 0 unchanged
    add_row(OP_READ, 32'h0000_0000, 4'hF, '0, ErrRspData, 1'b1);
    add_row(OP_WRITE, 32'h2000_0000, 4'hF, $urandom, ErrRspData, 1'b1);
    add_row(OP_WRITE, sram_addr(SramNumWords), 4'hF, 32'hFFFF_FFFF, ErrRspData, 1'b1);
    add_row(OP_READ, TimerBase + 32'h1000, 4'hF, '0, ErrRspData, 1'b1);
    add_row(OP_READ, sram_addr(0), 4'hF, '0, sram_model[0], 1'b0);
    seg_end[1] = row_cnt;
    add_row(OP_READ, SocCtrlBase, 4'hF, '0, BootAddrDefault, 1'b0);
    add_row(OP_WRITE, SocCtrlBase, 4'hF, 32'h1000_0080, '0, 1'b0);
    add_row(OP_READ, SocCtrlBase, 4'hF, '0, 32'h1000_0080, 1'b0);
    seg_end[2] = row_cnt;
    // Mixed targets run after the GPIO sequence
    add_row(OP_READ, sram_addr(3), 4'hF, '0, sram_model[3], 1'b0);
    add_row(OP_READ, GpioBase + addr_t'(GpioInOff), 4'hF, '0, data_t'(InVal), 1'b0);
    add_row(OP_READ, 32'h0400_0000, 4'hF, '0, ErrRspData, 1'b1);
    add_row(OP_READ, sram_addr(6), 4'hF, '0, sram_model[6], 1'b0);
    add_row(OP_READ, GpioBase + addr_t'(GpioDirOff), 4'hF, '0, data_t'(DirVal), 1'b0);
    seg_end[3] = row_cnt;
  endtask

  // --------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------
  initial begin
    int gap;
    void'($urandom(37));
    rst_n_i    = 1'b0;
    gpio_i     = '0;
    fetch_en_i = 1'b0;
    idle_bus();
    build_table();
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;

    check_bit(bus_gnt_o, 1'b0, "bus_gnt_o after reset");
    check_bit(bus_rvalid_o, 1'b0, "bus_rvalid_o after reset");
    check_irq(irq_o, 2'b00, "after reset");
    check_gpio(gpio_out_en_o, '0, "gpio_out_en_o after reset");
    check_gpio(gpio_o, '0, "gpio_o after reset");
    check_data(boot_addr_o, BootAddrDefault, "boot_addr_o after reset");
    check_bit(fetch_en_o, 1'b0, "fetch_en_o after reset");

    @(negedge clk_i);
    run_rows(0, seg_end[0]);
    run_rows(seg_end[0], seg_end[1]);
    run_rows(seg_end[1], seg_end[2]);
    check_data(boot_addr_o, 32'h1000_0080, "boot_addr_o after write");

    // Fetch enable is pin OR register
    for (int r = 0; r < 2; r++) begin
      for (int p = 0; p < 2; p++) begin
        write_reg(SocCtrlBase + addr_t'(SocCtrlFetchEnOff), data_t'(r));
        fetch_en_i = p[0];
        @(negedge clk_i);
        check_bit(fetch_en_o, r[0] | p[0], "fetch_en_o");
      end
    end

    write_reg(GpioBase + addr_t'(GpioDirOff), data_t'(DirVal));
    write_reg(GpioBase + addr_t'(GpioOutOff), data_t'(OutVal));
    check_gpio(gpio_out_en_o, DirVal, "gpio_out_en_o");
    check_gpio(gpio_o, OutVal, "gpio_o");

    // Edge interrupt on pin 0 only
    write_reg(GpioBase + addr_t'(GpioIrqEnOff), 32'h1);
    gpio_i = 8'h01;
    wait_irq(1, 6);
    check_irq(irq_o, 2'b10, "gpio edge");
    read_reg(GpioBase + addr_t'(GpioIrqStatusOff), 32'h1);
    write_reg(GpioBase + addr_t'(GpioIrqStatusOff), 32'h1);
    check_irq(irq_o, 2'b00, "gpio status cleared");
    gpio_i = 8'h03;
    repeat (5) @(negedge clk_i);
    check_irq(irq_o, 2'b00, "edge on disabled pin");
    read_reg(GpioBase + addr_t'(GpioIrqStatusOff), '0);
    gpio_i = InVal;
    repeat (2) @(negedge clk_i);
    read_reg(GpioBase + addr_t'(GpioInOff), data_t'(InVal));

    run_rows(seg_end[2], seg_end[3]);

    // Timer pulses one cycle wide and CMP+1 apart
    write_reg(TimerBase + addr_t'(TimerCmpOff), data_t'(TimerCmp));
    write_reg(TimerBase + addr_t'(TimerCtrlOff), 32'h1);
    wait_irq(0, 4 * (TimerCmp + 1) + 8);
    repeat (2) begin
      check_irq(irq_o, 2'b01, "timer pulse");
      @(negedge clk_i);
      check_irq(irq_o, 2'b00, "cycle after timer pulse");
      gap = 1;
      while (irq_o[0] !== 1'b1) begin
        @(negedge clk_i);
        gap++;
        if (gap > 2 * (TimerCmp + 1)) begin
          $display("Timer interrupt did not repeat within %0d cycles", gap);
          abort_run();
        end
      end
      check_data(data_t'(gap), data_t'(TimerCmp + 1), "timer pulse spacing");
    end

    if (u_soc_domain.u_demux.u_chk.fail_cnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("%0d bus timing assertions failed", u_soc_domain.u_demux.u_chk.fail_cnt);
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== tests/soc_domain_chk.sv ====
/*
 * Bus timing checker
 * Concurrent assertions on the manager side of the address decoder,
 * bound into every obi_addr_demux instance
 */
`timescale 1ns/1ns
`default_nettype none

module soc_domain_chk (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_i,
  input logic gnt_i,
  input logic rvalid_i,
  input logic err_i
);

  // Count of failed assertions, read back by the testbench
  int fail_cnt = 0;

  // All subordinates are always ready
  a_gnt_follows_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) gnt_i == req_i
  ) else begin
    $error("gnt differs from req");
    fail_cnt++;
  end

  // Response one cycle after acceptance
  a_rsp_after_accept: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (req_i && gnt_i) |=> rvalid_i
  ) else begin
    $error("no rvalid one cycle after an accepted access");
    fail_cnt++;
  end

  a_no_stray_rvalid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rvalid_i |-> $past(req_i && gnt_i)
  ) else begin
    $error("rvalid without an accepted access one cycle before");
    fail_cnt++;
  end

  a_err_with_rvalid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) err_i |-> rvalid_i
  ) else begin
    $error("err high while rvalid is low");
    fail_cnt++;
  end

endmodule

bind obi_addr_demux soc_domain_chk u_chk (
  .clk_i    ( clk_i          ),
  .rst_n_i  ( rst_n_i        ),
  .req_i    ( mgr_bus.req    ),
  .gnt_i    ( mgr_bus.gnt    ),
  .rvalid_i ( mgr_bus.rvalid ),
  .err_i    ( mgr_bus.err    )
);

`default_nettype wire

// ==== logic/soc_domain.sv ====
/*
 * SoC peripheral domain
 * One external bus manager reaches SRAM, SoC control, GPIO and timer
 * through a flat address decoder; interrupts gathered into irq_o
 */
`timescale 1ns/1ns
`default_nettype none

module soc_domain
  import soc_pkg::*;
#(
  parameter int unsigned GpioCount    = 8,
  parameter int unsigned SramNumWords = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  logic                 bus_req_i,
  input  logic                 bus_we_i,
  input  addr_t                bus_addr_i,
  input  be_t                  bus_be_i,
  input  data_t                bus_wdata_i,
  output logic                 bus_gnt_o,
  output logic                 bus_rvalid_o,
  output data_t                bus_rdata_o,
  output logic                 bus_err_o,

  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,

  output irq_vec_t             irq_o,
  input  logic                 fetch_en_i,
  output addr_t                boot_addr_o,
  output logic                 fetch_en_o
);

  logic timer_irq;
  logic gpio_irq;

  obi_bus_if mgr_bus ();
  obi_bus_if sram_bus ();
  obi_bus_if ctrl_bus ();
  obi_bus_if gpio_bus ();
  obi_bus_if timer_bus ();

  // --------------------------------------------------------------------
  // External manager port
  // --------------------------------------------------------------------
  assign mgr_bus.req   = bus_req_i;
  assign mgr_bus.we    = bus_we_i;
  assign mgr_bus.addr  = bus_addr_i;
  assign mgr_bus.be    = bus_be_i;
  assign mgr_bus.wdata = bus_wdata_i;

  assign bus_gnt_o    = mgr_bus.gnt;
  assign bus_rvalid_o = mgr_bus.rvalid;
  assign bus_rdata_o  = mgr_bus.rdata;
  assign bus_err_o    = mgr_bus.err;

  // Bit 0 timer, bit 1 GPIO
  assign irq_o = {gpio_irq, timer_irq};

  obi_addr_demux #(
    .SramNumWords ( SramNumWords )
  ) u_demux (
    .clk_i,
    .rst_n_i,
    .mgr_bus   ( mgr_bus   ),
    .sram_bus  ( sram_bus  ),
    .ctrl_bus  ( ctrl_bus  ),
    .gpio_bus  ( gpio_bus  ),
    .timer_bus ( timer_bus )
  );

  sram_bank #(
    .SramNumWords ( SramNumWords )
  ) u_sram (
    .clk_i,
    .rst_n_i,
    .bus ( sram_bus )
  );

  soc_ctrl_regs u_soc_ctrl (
    .clk_i,
    .rst_n_i,
    .bus         ( ctrl_bus    ),
    .fetch_en_i,
    .boot_addr_o,
    .fetch_en_o
  );

  gpio_ctrl #(
    .GpioCount ( GpioCount )
  ) u_gpio (
    .clk_i,
    .rst_n_i,
    .bus           ( gpio_bus ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .irq_o         ( gpio_irq )
  );

  timer_unit u_timer (
    .clk_i,
    .rst_n_i,
    .bus   ( timer_bus ),
    .irq_o ( timer_irq )
  );

endmodule

`default_nettype wire

// ==== logic/timer_unit.sv ====
/*
 * Compare timer
 * Free-running counter that clears on reaching the compare value
 * and pulses its interrupt for one cycle
 */
`timescale 1ns/1ns
`default_nettype none

module timer_unit
  import soc_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  obi_bus_if.sbr bus,
  output logic   irq_o
);

  data_t    cnt_q;
  data_t    cmp_q;
  logic     en_q;
  logic     irq_q;
  logic     match;
  reg_off_t off;
  logic     wr_en;
  data_t    ctrl_wr;
  data_t    cnt_wr;
  data_t    cmp_wr;
  data_t    rd_data;
  data_t    rdata_q;
  logic     rvalid_q;

  assign off   = bus.addr[WinBits-1:0];
  assign wr_en = bus.req && bus.we;

  assign ctrl_wr = apply_be(data_t'(en_q), bus.wdata, bus.be);
  assign cnt_wr  = apply_be(cnt_q, bus.wdata, bus.be);
  assign cmp_wr  = apply_be(cmp_q, bus.wdata, bus.be);

  assign match = en_q && (cnt_q == cmp_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q    <= '0;
      cmp_q    <= '0;
      en_q     <= 1'b0;
      irq_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      irq_q    <= match;
      if (wr_en && off == TimerCtrlOff) en_q  <= ctrl_wr[0];
      if (wr_en && off == TimerCmpOff)  cmp_q <= cmp_wr;
      // Bus write to CNT overrides counting
      if (wr_en && off == TimerCntOff) begin
        cnt_q <= cnt_wr;
      end else if (en_q) begin
        cnt_q <= match ? '0 : cnt_q + data_t'(1);
      end
    end
  end

  always_comb begin
    case (off)
      TimerCtrlOff: rd_data = data_t'(en_q);
      TimerCntOff:  rd_data = cnt_q;
      TimerCmpOff:  rd_data = cmp_q;
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) rdata_q <= bus.we ? '0 : rd_data;
  end

  assign bus.gnt    = bus.req;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign irq_o = irq_q;

endmodule

`default_nettype wire

// ==== logic/gpio_ctrl.sv ====
/*
 * GPIO controller
 * Direction and output registers, two-flop input synchronizer and
 * a rising-edge interrupt with write-one-to-clear status
 */
`timescale 1ns/1ns
`default_nettype none

module gpio_ctrl
  import soc_pkg::*;
#(
  parameter int unsigned GpioCount = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  obi_bus_if.sbr               bus,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic                 irq_o
);

  logic [GpioCount-1:0] sync_meta_q;
  logic [GpioCount-1:0] sync_q;
  logic [GpioCount-1:0] sync_prev_q;
  logic [GpioCount-1:0] dir_q;
  logic [GpioCount-1:0] out_q;
  logic [GpioCount-1:0] irq_en_q;
  logic [GpioCount-1:0] irq_status_q;
  logic [GpioCount-1:0] rise;
  logic [GpioCount-1:0] status_clr;
  reg_off_t             off;
  logic                 wr_en;
  data_t                dir_wr;
  data_t                out_wr;
  data_t                irq_en_wr;
  data_t                clr_mask;
  data_t                rd_data;
  data_t                rdata_q;
  logic                 rvalid_q;

  assign off   = bus.addr[WinBits-1:0];
  assign wr_en = bus.req && bus.we;

  assign dir_wr    = apply_be(data_t'(dir_q), bus.wdata, bus.be);
  assign out_wr    = apply_be(data_t'(out_q), bus.wdata, bus.be);
  assign irq_en_wr = apply_be(data_t'(irq_en_q), bus.wdata, bus.be);
  assign clr_mask  = apply_be('0, bus.wdata, bus.be);

  // Enabled rising edges of the synchronized pins
  assign rise       = sync_q & ~sync_prev_q & irq_en_q;
  assign status_clr = (wr_en && off == GpioIrqStatusOff) ? clr_mask[GpioCount-1:0] : '0;

  // --------------------------------------------------------------------
  // Synchronizer and registers
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_meta_q  <= '0;
      sync_q       <= '0;
      sync_prev_q  <= '0;
      dir_q        <= '0;
      out_q        <= '0;
      irq_en_q     <= '0;
      irq_status_q <= '0;
      rvalid_q     <= 1'b0;
    end else begin
      sync_meta_q  <= gpio_i;
      sync_q       <= sync_meta_q;
      sync_prev_q  <= sync_q;
      rvalid_q     <= bus.req;
      // A new edge wins over a clear in the same cycle
      irq_status_q <= (irq_status_q & ~status_clr) | rise;
      if (wr_en && off == GpioDirOff)   dir_q    <= dir_wr[GpioCount-1:0];
      if (wr_en && off == GpioOutOff)   out_q    <= out_wr[GpioCount-1:0];
      if (wr_en && off == GpioIrqEnOff) irq_en_q <= irq_en_wr[GpioCount-1:0];
    end
  end

  always_comb begin
    case (off)
      GpioDirOff:       rd_data = data_t'(dir_q);
      GpioOutOff:       rd_data = data_t'(out_q);
      GpioInOff:        rd_data = data_t'(sync_q);
      GpioIrqEnOff:     rd_data = data_t'(irq_en_q);
      GpioIrqStatusOff: rd_data = data_t'(irq_status_q);
      default:          rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) rdata_q <= bus.we ? '0 : rd_data;
  end

  assign bus.gnt    = bus.req;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign gpio_o        = out_q;
  assign gpio_out_en_o = dir_q;
  assign irq_o         = |irq_status_q;

endmodule

`default_nettype wire

// ==== logic/soc_ctrl_regs.sv ====
/*
 * SoC control registers
 * Boot address and fetch enable, both readable over the bus
 */
`timescale 1ns/1ns
`default_nettype none

module soc_ctrl_regs
  import soc_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  obi_bus_if.sbr bus,
  input  logic   fetch_en_i,
  output addr_t  boot_addr_o,
  output logic   fetch_en_o
);

  addr_t    boot_addr_q;
  logic     fetch_en_q;
  reg_off_t off;
  logic     wr_en;
  data_t    boot_addr_wr;
  data_t    fetch_en_wr;
  data_t    rd_data;
  data_t    rdata_q;
  logic     rvalid_q;

  assign off   = bus.addr[WinBits-1:0];
  assign wr_en = bus.req && bus.we;

  assign boot_addr_wr = apply_be(boot_addr_q, bus.wdata, bus.be);
  assign fetch_en_wr  = apply_be(data_t'(fetch_en_q), bus.wdata, bus.be);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= BootAddrDefault;
      fetch_en_q  <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      if (wr_en && off == SocCtrlBootAddrOff) boot_addr_q <= boot_addr_wr;
      if (wr_en && off == SocCtrlFetchEnOff)  fetch_en_q  <= fetch_en_wr[0];
    end
  end

  // Read mux, unknown offsets read 0
  always_comb begin
    case (off)
      SocCtrlBootAddrOff: rd_data = boot_addr_q;
      SocCtrlFetchEnOff:  rd_data = data_t'(fetch_en_q);
      default:            rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) rdata_q <= bus.we ? '0 : rd_data;
  end

  assign bus.gnt    = bus.req;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign boot_addr_o = boot_addr_q;
  // Pin or register can start the fetch
  assign fetch_en_o  = fetch_en_q | fetch_en_i;

endmodule

`default_nettype wire

// ==== logic/sram_bank.sv ====
/*
 * SRAM bank
 * Word-addressed memory with byte-enabled writes and
 * one-cycle read latency
 */
`timescale 1ns/1ns
`default_nettype none

module sram_bank
  import soc_pkg::*;
#(
  parameter int unsigned SramNumWords = 256
) (
  input  logic   clk_i,
  input  logic   rst_n_i,
  obi_bus_if.sbr bus
);

  localparam int unsigned IdxWidth = $clog2(SramNumWords);

  data_t               mem_q [SramNumWords];
  logic [IdxWidth-1:0] word_idx;
  data_t               rdata_q;
  logic                rvalid_q;

  // Byte address to word index
  assign word_idx = bus.addr[IdxWidth+1:2];

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        mem_q[word_idx] <= apply_be(mem_q[word_idx], bus.wdata, bus.be);
        rdata_q         <= '0;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) rvalid_q <= 1'b0;
    else          rvalid_q <= bus.req;
  end

  // Always ready
  assign bus.gnt    = bus.req;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

`default_nettype wire

// ==== logic/obi_addr_demux.sv ====
/*
 * Flat OBI address decoder
 * Routes each request to one subordinate, returns its response one
 * cycle later and answers unmapped addresses with an error
 */
`timescale 1ns/1ns
`default_nettype none

module obi_addr_demux
  import soc_pkg::*;
#(
  parameter int unsigned SramNumWords = 256
) (
  input  logic   clk_i,
  input  logic   rst_n_i,
  obi_bus_if.sbr mgr_bus,
  obi_bus_if.mgr sram_bus,
  obi_bus_if.mgr ctrl_bus,
  obi_bus_if.mgr gpio_bus,
  obi_bus_if.mgr timer_bus
);

  localparam addr_t SramBytes = addr_t'(SramNumWords * 4);

  target_e req_tgt;
  target_e rsp_tgt_q;
  logic    accepted;
  logic    err_rvalid_q;

  // Address decode
  always_comb begin
    req_tgt = TGT_ERROR;
    if (mgr_bus.addr >= SramBase && mgr_bus.addr < SramBase + SramBytes) begin
      req_tgt = TGT_SRAM;
    end else if (mgr_bus.addr[AddrWidth-1:WinBits] == SocCtrlBase[AddrWidth-1:WinBits]) begin
      req_tgt = TGT_SOC_CTRL;
    end else if (mgr_bus.addr[AddrWidth-1:WinBits] == GpioBase[AddrWidth-1:WinBits]) begin
      req_tgt = TGT_GPIO;
    end else if (mgr_bus.addr[AddrWidth-1:WinBits] == TimerBase[AddrWidth-1:WinBits]) begin
      req_tgt = TGT_TIMER;
    end
  end

  // --------------------------------------------------------------------
  // Request fan-out, req only to the decoded target
  // --------------------------------------------------------------------
  assign sram_bus.req  = mgr_bus.req && (req_tgt == TGT_SRAM);
  assign ctrl_bus.req  = mgr_bus.req && (req_tgt == TGT_SOC_CTRL);
  assign gpio_bus.req  = mgr_bus.req && (req_tgt == TGT_GPIO);
  assign timer_bus.req = mgr_bus.req && (req_tgt == TGT_TIMER);

  assign sram_bus.we     = mgr_bus.we;
  assign sram_bus.addr   = mgr_bus.addr;
  assign sram_bus.be     = mgr_bus.be;
  assign sram_bus.wdata  = mgr_bus.wdata;
  assign ctrl_bus.we     = mgr_bus.we;
  assign ctrl_bus.addr   = mgr_bus.addr;
  assign ctrl_bus.be     = mgr_bus.be;
  assign ctrl_bus.wdata  = mgr_bus.wdata;
  assign gpio_bus.we     = mgr_bus.we;
  assign gpio_bus.addr   = mgr_bus.addr;
  assign gpio_bus.be     = mgr_bus.be;
  assign gpio_bus.wdata  = mgr_bus.wdata;
  assign timer_bus.we    = mgr_bus.we;
  assign timer_bus.addr  = mgr_bus.addr;
  assign timer_bus.be    = mgr_bus.be;
  assign timer_bus.wdata = mgr_bus.wdata;

  // Error window grants on its own
  always_comb begin
    case (req_tgt)
      TGT_SRAM:     mgr_bus.gnt = sram_bus.gnt;
      TGT_SOC_CTRL: mgr_bus.gnt = ctrl_bus.gnt;
      TGT_GPIO:     mgr_bus.gnt = gpio_bus.gnt;
      TGT_TIMER:    mgr_bus.gnt = timer_bus.gnt;
      default:      mgr_bus.gnt = mgr_bus.req;
    endcase
  end

  assign accepted = mgr_bus.req && mgr_bus.gnt;

  // Remember who owes the next response
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_tgt_q    <= TGT_ERROR;
      err_rvalid_q <= 1'b0;
    end else begin
      err_rvalid_q <= accepted && (req_tgt == TGT_ERROR);
      if (accepted) rsp_tgt_q <= req_tgt;
    end
  end

  // --------------------------------------------------------------------
  // Response mux
  // --------------------------------------------------------------------
  always_comb begin
    mgr_bus.rvalid = 1'b0;
    mgr_bus.rdata  = '0;
    mgr_bus.err    = 1'b0;
    case (rsp_tgt_q)
      TGT_SRAM: begin
        mgr_bus.rvalid = sram_bus.rvalid;
        mgr_bus.rdata  = sram_bus.rdata;
        mgr_bus.err    = sram_bus.err;
      end
      TGT_SOC_CTRL: begin
        mgr_bus.rvalid = ctrl_bus.rvalid;
        mgr_bus.rdata  = ctrl_bus.rdata;
        mgr_bus.err    = ctrl_bus.err;
      end
      TGT_GPIO: begin
        mgr_bus.rvalid = gpio_bus.rvalid;
        mgr_bus.rdata  = gpio_bus.rdata;
        mgr_bus.err    = gpio_bus.err;
      end
      TGT_TIMER: begin
        mgr_bus.rvalid = timer_bus.rvalid;
        mgr_bus.rdata  = timer_bus.rdata;
        mgr_bus.err    = timer_bus.err;
      end
      default: begin
        mgr_bus.rvalid = err_rvalid_q;
        mgr_bus.rdata  = ErrRspData;
        mgr_bus.err    = err_rvalid_q;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/obi_bus_if.sv ====
/*
 * OBI word bus
 * Request channel with req/gnt, response channel with rvalid,
 * rdata and err one cycle after acceptance
 */
`timescale 1ns/1ns
`default_nettype none

interface obi_bus_if
  import soc_pkg::*;
();

  // Request
  logic  req;
  logic  we;
  addr_t addr;
  be_t   be;
  data_t wdata;
  logic  gnt;

  // Response
  logic  rvalid;
  data_t rdata;
  logic  err;

  modport mgr (
    output req, we, addr, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport sbr (
    input  req, we, addr, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

`default_nettype wire

// ==== logic/soc_pkg.sv ====
/*
 * SoC peripheral domain package
 * Bus widths, address map, register offsets and shared types
 */
`default_nettype none

package soc_pkg;

  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned NumIrqs   = 2;
  localparam int unsigned WinBits   = 12;

  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth/8-1:0] be_t;
  typedef logic [NumIrqs-1:0]     irq_vec_t;
  typedef logic [WinBits-1:0]     reg_off_t;

  // Subordinate picked by the address decoder
  typedef enum logic [2:0] {
    TGT_ERROR,
    TGT_SRAM,
    TGT_SOC_CTRL,
    TGT_GPIO,
    TGT_TIMER
  } target_e;

  // --------------------------------------------------------------------
  // Address map, 4 KiB peripheral windows
  // --------------------------------------------------------------------
  localparam addr_t SramBase        = 32'h1000_0000;
  localparam addr_t SocCtrlBase     = 32'h0300_0000;
  localparam addr_t GpioBase        = 32'h0300_1000;
  localparam addr_t TimerBase       = 32'h0300_2000;
  localparam addr_t BootAddrDefault = SramBase;
  localparam data_t ErrRspData      = 32'hBADC_AB1E;

  // Register offsets inside each window
  localparam reg_off_t SocCtrlBootAddrOff = 12'h000;
  localparam reg_off_t SocCtrlFetchEnOff  = 12'h004;
  localparam reg_off_t GpioDirOff         = 12'h000;
  localparam reg_off_t GpioOutOff         = 12'h004;
  localparam reg_off_t GpioInOff          = 12'h008;
  localparam reg_off_t GpioIrqEnOff       = 12'h00C;
  localparam reg_off_t GpioIrqStatusOff   = 12'h010;
  localparam reg_off_t TimerCtrlOff       = 12'h000;
  localparam reg_off_t TimerCntOff        = 12'h004;
  localparam reg_off_t TimerCmpOff        = 12'h008;

  // Merge new bytes into an old word under byte enables
  function automatic data_t apply_be(data_t old_data, data_t new_data, be_t be);
    data_t merged;
    merged = old_data;
    for (int i = 0; i < DataWidth / 8; i++) begin
      if (be[i]) merged[8*i +: 8] = new_data[8*i +: 8];
    end
    return merged;
  endfunction

endpackage

`default_nettype wire
